/* src/sb_rep_consts.svh */
// Width and depth constants for the sideband repeater, included by packages and RTL that size storage
`ifndef SB_REP_CONSTS_SVH
`define SB_REP_CONSTS_SVH

// Message word width in bits
`define SB_WORD_W 32

// Entries per class queue, kept a power of two
`define SB_REP_DEPTH 4

// Posted-count tag width
// log2 of the depth plus one, so the tag counts modulo twice the depth
`define SB_TAG_W 3

`endif

/* src/sb_msg_pkg.sv */
// Message-level types shared by the repeater RTL and the testbench, imported where words or classes are used
`include "sb_rep_consts.svh"

package sb_msg_pkg;

  // One sideband message word
  typedef logic [`SB_WORD_W-1:0] sb_word_t;

  // Message class
  // Value doubles as the bit index into put, free and empty vectors
  typedef enum logic {
    sb_pc = 1'b0,
    sb_np = 1'b1
  } sb_class_e;

endpackage

/* src/sb_rep_pkg.sv */
// Repeater-internal types for arbitration and ordering, imported by the ingress and egress blocks
`include "sb_rep_consts.svh"

package sb_rep_pkg;

  // Class the egress arbiter serves first on the next contention
  typedef enum logic {
    pref_pc = 1'b0,
    pref_np = 1'b1
  } sb_pref_e;

  // Running posted-word count
  // Wraps at twice the queue depth
  typedef logic [`SB_TAG_W-1:0] sb_tag_t;

endpackage

/* src/sb_queue_if.sv */
// Queue-state link between repeater ingress and egress, ingress uses the queue modport and egress sched
`timescale 1ns/1ps

interface sb_queue_if
  import sb_msg_pkg::*;
();

  // Combinational heads of the two class queues
  sb_word_t   pc_head;
  sb_word_t   np_head;

  // Per-class empty flags, indexed by sb_class_e
  logic [1:0] empty;

  // High when the np head has no older posted word left in the pc queue
  logic       fence_off_np;

  // Per-class pop, takes effect at the next edge
  logic [1:0] pop;

  // Storage side
  modport queue (
    output pc_head, np_head, empty, fence_off_np,
    input  pop
  );

  // Scheduler side
  modport sched (
    input  pc_head, np_head, empty, fence_off_np,
    output pop
  );

endinterface

/* src/sb_rep_fifo.sv */
// Synchronous circular FIFO for one message class, instantiated per class inside the repeater ingress
`timescale 1ns/1ps

`include "sb_rep_consts.svh"

module sb_rep_fifo
  import sb_msg_pkg::*;
#(
  // Number of entries, power of two
  parameter int DEPTH = `SB_REP_DEPTH
) (
  input  logic     side_clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  sb_word_t wdata,
  output sb_word_t rdata,
  output logic     empty,
  output logic     full
);

  localparam int AW = $clog2(DEPTH);

  sb_word_t    mem [DEPTH];

  // Pointers carry one wrap bit above the index
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        wr_en;
  logic        rd_en;

  // Writes into a full queue and reads from an empty one are ignored
  assign wr_en = push & ~full;
  assign rd_en = pop & ~empty;

  // --------------------
  // Pointer state
  always_ff @(posedge side_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge side_clk) begin
    if (wr_en) mem[wr_ptr[AW-1:0]] <= wdata;
  end

  // --------------------
  // Same index with differing wrap bits means full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Head is visible without a read cycle
  assign rdata = mem[rd_ptr[AW-1:0]];

endmodule

/* src/sb_rep_ingress.sv */
// Repeater ingress taking upstream puts into the class queues and producing the np ordering fence
`timescale 1ns/1ps

`include "sb_rep_consts.svh"

module sb_rep_ingress
  import sb_msg_pkg::*, sb_rep_pkg::*;
(
  input  logic       side_clk,
  input  logic       reset,
  input  logic       mst_pcput,
  input  logic       mst_npput,
  input  sb_word_t   mst_data,
  output logic       mst_pcfree,
  output logic       mst_npfree,
  sb_queue_if.queue  q
);

  localparam int TIX_W = $clog2(`SB_REP_DEPTH);

  logic                     pc_empty;
  logic                     pc_full;
  logic                     np_empty;
  logic                     np_full;
  logic                     pc_push_ok;
  logic                     pc_pop_ok;
  logic                     np_push_ok;
  logic                     np_pop_ok;

  // Posted enqueue and dequeue counts
  sb_tag_t                  pc_in;
  sb_tag_t                  pc_out;

  // Tag store kept in step with the np queue
  sb_tag_t                  tag_mem [`SB_REP_DEPTH];
  logic [TIX_W-1:0]         tag_wix;
  logic [TIX_W-1:0]         tag_rix;
  logic [`SB_REP_DEPTH-1:0] tag_hit;
  logic [`SB_REP_DEPTH-1:0] tag_sat;

  // --------------------
  // Class queues
  sb_rep_fifo #(.DEPTH(`SB_REP_DEPTH)) i_pc_fifo (
    .side_clk (side_clk),
    .reset    (reset),
    .push     (mst_pcput),
    .pop      (q.pop[sb_pc]),
    .wdata    (mst_data),
    .rdata    (q.pc_head),
    .empty    (pc_empty),
    .full     (pc_full)
  );

  sb_rep_fifo #(.DEPTH(`SB_REP_DEPTH)) i_np_fifo (
    .side_clk (side_clk),
    .reset    (reset),
    .push     (mst_npput),
    .pop      (q.pop[sb_np]),
    .wdata    (mst_data),
    .rdata    (q.np_head),
    .empty    (np_empty),
    .full     (np_full)
  );

  assign q.empty    = {np_empty, pc_empty};

  // Free follows the registered pointers, one cycle after a write or pop
  assign mst_pcfree = ~pc_full;
  assign mst_npfree = ~np_full;

  // Moves the FIFOs actually perform
  assign pc_push_ok = mst_pcput & ~pc_full;
  assign pc_pop_ok  = q.pop[sb_pc] & ~pc_empty;
  assign np_push_ok = mst_npput & ~np_full;
  assign np_pop_ok  = q.pop[sb_np] & ~np_empty;

  // --------------------
  // Posted counters and tag store indices
  always_ff @(posedge side_clk) begin
    if (reset) begin
      pc_in   <= '0;
      pc_out  <= '0;
      tag_wix <= '0;
      tag_rix <= '0;
    end else begin
      if (pc_push_ok) pc_in   <= pc_in + 1'b1;
      if (pc_pop_ok)  pc_out  <= pc_out + 1'b1;
      if (np_push_ok) tag_wix <= tag_wix + 1'b1;
      if (np_pop_ok)  tag_rix <= tag_rix + 1'b1;
    end
  end

  // A same-cycle pc put counts as younger than the np word
  always_ff @(posedge side_clk) begin
    if (np_push_ok) tag_mem[tag_wix] <= pc_in;
  end

  // Entry released once pc_out reaches its tag
  always_comb begin
    for (int i = 0; i < `SB_REP_DEPTH; i++) begin
      tag_hit[i] = (tag_mem[i] == pc_out);
    end
  end

  // pc_out keeps running while an np word waits on target free,
  // so the release is held per entry until the slot is rewritten
  always_ff @(posedge side_clk) begin
    if (reset) begin
      tag_sat <= '0;
    end else begin
      for (int i = 0; i < `SB_REP_DEPTH; i++) begin
        if (np_push_ok && (tag_wix == TIX_W'(i))) tag_sat[i] <= 1'b0;
        else                                      tag_sat[i] <= tag_sat[i] | tag_hit[i];
      end
    end
  end

  // Fence opens for an empty np queue or a released head
  assign q.fence_off_np = np_empty | tag_sat[tag_rix] | tag_hit[tag_rix];

endmodule

/* src/sb_rep_egress.sv */
// Repeater egress arbitrating the class queues and gating target puts against free, empty and fence
`timescale 1ns/1ps

module sb_rep_egress
  import sb_msg_pkg::*, sb_rep_pkg::*;
(
  input  logic       side_clk,
  input  logic       reset,
  input  logic       tgt_pcfree,
  input  logic       tgt_npfree,
  output logic       tgt_pcput,
  output logic       tgt_npput,
  output sb_word_t   tgt_data,
  sb_queue_if.sched  q
);

  sb_pref_e pref;
  logic     elig_pc;
  logic     elig_np;

  // --------------------
  // Eligibility
  // Data waiting and target free, np also needs the fence open
  assign elig_pc = tgt_pcfree & ~q.empty[sb_pc];
  assign elig_np = tgt_npfree & q.fence_off_np & ~q.empty[sb_np];

  // --------------------
  // Arbiter
  // Preferred class first, otherwise whichever is eligible
  always_comb begin
    if (pref == pref_pc) begin
      tgt_pcput = elig_pc;
      tgt_npput = elig_np & ~elig_pc;
    end else begin
      tgt_npput = elig_np;
      tgt_pcput = elig_pc & ~elig_np;
    end
  end

  // Each target put retires the queue head at the same edge
  assign q.pop = {tgt_npput, tgt_pcput};

  // Defaults to the pc head when idle
  assign tgt_data = tgt_npput ? q.np_head : q.pc_head;

  // --------------------
  // Preference flips to the class not just served
  always_ff @(posedge side_clk) begin
    if (reset) begin
      pref <= pref_pc;
    end else if (tgt_pcput) begin
      pref <= pref_np;
    end else if (tgt_npput) begin
      pref <= pref_pc;
    end
  end

endmodule

/* src/sb_rep_top.sv */
// Sideband repeater top level with plain upstream and target ports, the DUT seen by the testbench
`timescale 1ns/1ps

module sb_rep_top
  import sb_msg_pkg::*;
(
  input  logic     side_clk,
  input  logic     reset,

  // Upstream agent side
  input  logic     mst_pcput,
  input  logic     mst_npput,
  input  sb_word_t mst_data,
  output logic     mst_pcfree,
  output logic     mst_npfree,

  // Downstream target side
  input  logic     tgt_pcfree,
  input  logic     tgt_npfree,
  output logic     tgt_pcput,
  output logic     tgt_npput,
  output sb_word_t tgt_data
);

  // Queue state between the two halves
  sb_queue_if i_sb_queue_if ();

  sb_rep_ingress i_sb_rep_ingress (
    .side_clk   (side_clk),
    .reset      (reset),
    .mst_pcput  (mst_pcput),
    .mst_npput  (mst_npput),
    .mst_data   (mst_data),
    .mst_pcfree (mst_pcfree),
    .mst_npfree (mst_npfree),
    .q          (i_sb_queue_if.queue)
  );

  sb_rep_egress i_sb_rep_egress (
    .side_clk   (side_clk),
    .reset      (reset),
    .tgt_pcfree (tgt_pcfree),
    .tgt_npfree (tgt_npfree),
    .tgt_pcput  (tgt_pcput),
    .tgt_npput  (tgt_npput),
    .tgt_data   (tgt_data),
    .q          (i_sb_queue_if.sched)
  );

endmodule

/* verif/sb_rep_chk.sv */
// Assertions on put legality and reset behavior that bind attaches to every repeater egress
`timescale 1ns/1ps

module sb_rep_chk
  import sb_msg_pkg::*;
(
  input logic       side_clk,
  input logic       reset,
  input logic       tgt_pcput,
  input logic       tgt_npput,
  input logic [1:0] empty,
  input logic       fence_off_np
);

  // Failed assertion count
  int fails = 0;

  // Puts only from a queue that holds a word
  a_put_not_empty: assert property (@(posedge side_clk) disable iff (reset)
    !(tgt_pcput && empty[sb_pc]) && !(tgt_npput && empty[sb_np]))
    else begin
      $error("target put from an empty queue");
      fails++;
    end

  // np head held back while older posted words remain
  a_np_fence: assert property (@(posedge side_clk) disable iff (reset)
    tgt_npput |-> fence_off_np)
    else begin
      $error("np put while the fence is on");
      fails++;
    end

  a_one_put: assert property (@(posedge side_clk) !(tgt_pcput && tgt_npput))
    else begin
      $error("both target puts high in one cycle");
      fails++;
    end

  a_reset_quiet: assert property (@(posedge side_clk) reset |-> !tgt_pcput && !tgt_npput)
    else begin
      $error("target put high during reset");
      fails++;
    end

endmodule

// Every egress instance gets the checks
bind sb_rep_egress sb_rep_chk i_sb_rep_chk (
  .side_clk     (side_clk),
  .reset        (reset),
  .tgt_pcput    (tgt_pcput),
  .tgt_npput    (tgt_npput),
  .empty        (q.empty),
  .fence_off_np (q.fence_off_np)
);

/* verif/sb_rep_checker.sv */
// Repeater scoreboard, models both class queues from the upstream puts and checks every target put
`timescale 1ns/1ps

module sb_rep_checker
  import sb_msg_pkg::*;
(
  input  logic     side_clk,
  input  logic     reset,
  input  logic     mst_pcput,
  input  logic     mst_npput,
  input  sb_word_t mst_data,
  input  logic     mst_pcfree,
  input  logic     mst_npfree,
  input  logic     tgt_pcput,
  input  logic     tgt_npput,
  input  sb_word_t tgt_data,
  output int       err_cnt,
  output int       pc_pending,
  output int       np_pending
);

  sb_word_t pc_q[$];
  sb_word_t np_q[$];
  // Posted arrivals seen before each np word
  int       np_tag_q[$];
  int       pc_arrived = 0;
  int       pc_delivered = 0;
  int       errs = 0;

  assign err_cnt    = errs;
  assign pc_pending = pc_q.size();
  assign np_pending = np_q.size();

  // --------------------
  // Reference model
  // Next word a class must deliver, in arrival order
  function automatic sb_word_t expected_word(input sb_class_e cls);
    if (cls == sb_pc) return pc_q[0];
    else return np_q[0];
  endfunction

  // np head may leave once every older posted word is delivered
  function automatic bit np_may_leave(input int delivered);
    return (np_tag_q.size() > 0) && (delivered >= np_tag_q[0]);
  endfunction

  // --------------------
  // Compare on the clock edge, target side before upstream side
  always @(posedge side_clk) begin
    if (reset) begin
      if (tgt_pcput || tgt_npput) begin
        $display("ERROR tgt_pcput/tgt_npput expected 0 got %h during reset",
                 {tgt_pcput, tgt_npput});
        errs++;
      end
      pc_q.delete();
      np_q.delete();
      np_tag_q.delete();
      pc_arrived   = 0;
      pc_delivered = 0;
    end else begin
      if (tgt_pcput && tgt_npput) begin
        $display("ERROR tgt_npput expected 0 got 1 with tgt_pcput also high");
        errs++;
      end
      if (tgt_pcput) begin
        if (pc_q.size() == 0) begin
          $display("ERROR tgt_pcput expected 0 got 1 with no posted word queued");
          errs++;
        end else begin
          if (tgt_data !== expected_word(sb_pc)) begin
            $display("ERROR tgt_data expected %h got %h", expected_word(sb_pc), tgt_data);
            errs++;
          end
          void'(pc_q.pop_front());
          pc_delivered++;
        end
      end else if (tgt_npput) begin
        if (np_q.size() == 0) begin
          $display("ERROR tgt_npput expected 0 got 1 with no np word queued");
          errs++;
        end else begin
          if (!np_may_leave(pc_delivered)) begin
            $display("ERROR tgt_npput expected 0 got 1 before older posted words left");
            errs++;
          end
          if (tgt_data !== expected_word(sb_np)) begin
            $display("ERROR tgt_data expected %h got %h", expected_word(sb_np), tgt_data);
            errs++;
          end
          void'(np_q.pop_front());
          void'(np_tag_q.pop_front());
        end
      end
      // A same-cycle posted word counts as younger than the np word
      if (mst_npput && mst_npfree) begin
        np_q.push_back(mst_data);
        np_tag_q.push_back(pc_arrived);
      end
      if (mst_pcput && mst_pcfree) begin
        pc_q.push_back(mst_data);
        pc_arrived++;
      end
    end
  end

endmodule

/* verif/sb_rep_tb.sv */
// Repeater testbench top that drives upstream puts and target frees and runs the directed and random tests
`timescale 1ns/1ps

`include "sb_rep_consts.svh"

module sb_rep_tb
  import sb_msg_pkg::*;
();

  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 96;
  localparam int RAND_CYCLES     = 600;
  // Roughly four times the stimulus length
  localparam int TIMEOUT_CYCLES  = 4 * (RESET_CYCLES + 4 * DIRECTED_CYCLES + RAND_CYCLES);

  logic        side_clk = 1'b0;
  logic        reset;
  logic        mst_pcput, mst_npput, mst_pcfree, mst_npfree;
  logic        tgt_pcfree, tgt_npfree, tgt_pcput, tgt_npput;
  sb_word_t    mst_data, tgt_data;
  logic [1:0]  sel;
  logic [31:0] lfsr = 32'h1813;
  int          cycles = 0;
  int          tb_errs = 0;
  int          err_cnt, pc_pending, np_pending;
  int          tests = 0;
  int          base = 0;
  int          cnt;

  always #4 side_clk = ~side_clk;

  sb_rep_top i_sb_rep_top (.*);

  sb_rep_checker i_checker (.*);

  // Galois LFSR, stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val = '0;
    for (int i = 0; i < nbits; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Failures seen by the tb, the scoreboard and the bound assertions
  function automatic int total_errors();
    return tb_errs + err_cnt + i_sb_rep_top.i_sb_rep_egress.i_sb_rep_chk.fails;
  endfunction

  // --------------------
  // Stimulus helpers, entered right after a falling edge
  task automatic put_word(input sb_class_e cls, input sb_word_t data);
    while (!(cls == sb_np ? mst_npfree : mst_pcfree)) @(negedge side_clk);
    mst_pcput = (cls == sb_pc);
    mst_npput = (cls == sb_np);
    mst_data  = data;
    @(negedge side_clk);
    mst_pcput = 1'b0;
    mst_npput = 1'b0;
  endtask

  // Wait until the model holds no undelivered word
  task automatic drain();
    while (pc_pending + np_pending != 0) @(negedge side_clk);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (total_errors() == base) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, total_errors() - base);
    base = total_errors();
  endtask

  // Run limit
  always @(posedge side_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, traffic never drained", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------
  initial begin
    reset      = 1'b1;
    mst_pcput  = 1'b0;
    mst_npput  = 1'b0;
    mst_data   = '0;
    tgt_pcfree = 1'b0;
    tgt_npfree = 1'b0;
    sel        = '0;
    repeat (RESET_CYCLES) @(negedge side_clk);
    reset = 1'b0;
    // Quiet target side and open upstream side
    if ({tgt_pcput, tgt_npput, mst_pcfree, mst_npfree} != 4'b0011) begin
      $display("ERROR tgt_pcput/tgt_npput/mst_pcfree/mst_npfree expected 3 got %h",
               {tgt_pcput, tgt_npput, mst_pcfree, mst_npfree});
      tb_errs++;
    end
    finish_test("reset state");

    tgt_pcfree = 1'b1;
    tgt_npfree = 1'b1;
    for (int i = 0; i < 8; i++) put_word(sb_pc, 32'hA000_0000 + i);
    drain();
    finish_test("posted only");

    for (int i = 0; i < 8; i++) put_word(sb_np, 32'hB000_0000 + i);
    drain();
    finish_test("non-posted only");

    // Posted words stuck at the target must hold back the np word
    tgt_pcfree = 1'b0;
    for (int i = 0; i < 3; i++) put_word(sb_pc, 32'hC000_0000 + i);
    put_word(sb_np, 32'hC0DE_0001);
    repeat (20) @(negedge side_clk);
    if (np_pending != 1) begin
      $display("ERROR np_pending expected 1 got %h", np_pending);
      tb_errs++;
    end
    tgt_pcfree = 1'b1;
    drain();
    finish_test("np fence");

    // Fill each queue until upstream free drops
    tgt_pcfree = 1'b0;
    tgt_npfree = 1'b0;
    for (int c = 0; c < 2; c++) begin
      cnt = 0;
      while ((c == 0 ? mst_pcfree : mst_npfree) && cnt <= `SB_REP_DEPTH) begin
        put_word(sb_class_e'(c), {16'h5000, 16'(cnt)});
        cnt++;
      end
      if (cnt != `SB_REP_DEPTH) begin
        $display("ERROR words before free fell expected %h got %h", `SB_REP_DEPTH, cnt);
        tb_errs++;
      end
    end
    tgt_pcfree = 1'b1;
    tgt_npfree = 1'b1;
    drain();
    finish_test("back-pressure");

    // Random puts and target frees with free high three times in four
    for (int i = 0; i < RAND_CYCLES; i++) begin
      tgt_pcfree = |rand_bits(2);
      tgt_npfree = |rand_bits(2);
      sel        = 2'(rand_bits(2));
      mst_data   = rand_bits(32);
      mst_pcput  = (sel == 2'd1) & mst_pcfree;
      mst_npput  = (sel == 2'd2) & mst_npfree;
      @(negedge side_clk);
    end
    mst_pcput  = 1'b0;
    mst_npput  = 1'b0;
    tgt_pcfree = 1'b1;
    tgt_npfree = 1'b1;
    drain();
    finish_test("random traffic");

    $display("summary: %0d tests run, %0d errors", tests, total_errors());
    if (total_errors() == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+src
src/sb_msg_pkg.sv
src/sb_rep_pkg.sv
src/sb_queue_if.sv
src/sb_rep_fifo.sv
src/sb_rep_ingress.sv
src/sb_rep_egress.sv
src/sb_rep_top.sv
verif/sb_rep_chk.sv
verif/sb_rep_checker.sv
verif/sb_rep_tb.sv

/* Makefile */
# Verilator build and run for the sideband repeater testbench

BIN := obj_dir/Vsb_rep_tb

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): sim.f $(wildcard src/*.sv src/*.svh verif/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module sb_rep_tb -o Vsb_rep_tb

run: $(BIN)
	-./$(BIN) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	grep -q "all tests passed" sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
